//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // ------------------------------
    // Widths and depths
    // ------------------------------
    localparam int MOD_DATA_W  = 32;    // Modifier entry, address reg, read data
    localparam int GROUP_W     = 5;     // Modifier group number
    localparam int MOD_NUM_W   = 5;     // Modifier number within a group
    localparam int MOD_DEPTH   = 1024;  // Group and number together
    localparam int PAGE_IDX_W  = 10;    // Page index
    localparam int PAGE_COUNT  = 1024;  // Pages in the attribute store
    localparam int FRAME_W     = 20;    // Page map entry
    localparam int INSTR_MOD_W = 4;     // Instruction modifier field

    // Bit fields of the data word
    localparam int GROUP_LSB   = 5;     // Group sits at data[9:5]
    localparam int PAGE_LSB    = 10;    // Page index sits at data[19:10]

    // ------------------------------
    // Command opcodes
    // ------------------------------
    typedef enum logic [3:0] {
        NOP          = 4'd0,
        SET_GROUP    = 4'd1,    // Group from data[9:5]
        SET_PAGE     = 4'd2,    // Page index from data[19:10]
        SET_ADDR     = 4'd3,    // Full address word
        MOD_WRITE    = 4'd4,
        MOD_READ     = 4'd5,
        ATTR_WRITE   = 4'd6,    // Invalid from data[1], read-only from data[2]
        ATTR_READ    = 4'd7,
        REPRIO_WRITE = 4'd8,    // Bit from data[0]
        REPRIO_READ  = 4'd9,
        MAP_WRITE    = 4'd10,
        MAP_READ     = 4'd11,
        START_FILL   = 4'd12    // Ones from current page to the last one
    } cmd_op_t;

    // Modifier number sources
    typedef enum logic [1:0] {
        SRC_U    = 2'd0,        // Low bits of the address register
        SRC_IRA  = 2'd1,        // Instruction modifier field
        SRC_NONE = 2'd2,        // Number zero
        SRC_MP   = 2'd3         // Microinstruction number, inverted
    } mn_src_t;

    // Fill sequencer states
    typedef enum logic {
        FILL_IDLE = 1'b0,
        FILL_RUN  = 1'b1
    } fill_state_t;

endpackage

`default_nettype wire

//--- special_regs.sv
`default_nettype none
`timescale 1ns/1ps

module special_regs (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  mmu_pkg::cmd_op_t            i_cmd,          // Current command
    input  wire  [mmu_pkg::MOD_DATA_W-1:0]    i_data,         // Command data
    input  wire  [mmu_pkg::MOD_DATA_W-1:0]    i_mod_rdata,    // Modifier entry
    input  wire  [2:0]                        i_attr_rdata,   // {ro, inv, 0}
    input  wire                               i_reprio_rdata, // Reprioritize bit
    input  wire  [mmu_pkg::FRAME_W-1:0]       i_map_rdata,    // Page map entry
    output logic [mmu_pkg::GROUP_W-1:0]       o_group,        // Modifier group register
    output logic [mmu_pkg::PAGE_IDX_W-1:0]    o_page_idx,     // Physical page register
    output logic [mmu_pkg::MOD_DATA_W-1:0]    o_addr,         // Address register
    output logic                              o_mod_we,
    output logic                              o_attr_we,
    output logic                              o_reprio_we,
    output logic                              o_map_we,
    output logic                              o_fill_start,
    output logic [mmu_pkg::MOD_DATA_W-1:0]    o_rdata,        // Registered read-back
    output logic                              o_rvalid        // One cycle after a read
);
    import mmu_pkg::*;

    logic                  rd_cmd;      // Any read command this cycle
    logic [MOD_DATA_W-1:0] rd_sel;      // Selected read value, zero-extended

    // ------------------------------
    // Write strobes
    // ------------------------------
    assign o_mod_we     = (i_cmd == MOD_WRITE);
    assign o_attr_we    = (i_cmd == ATTR_WRITE);
    assign o_reprio_we  = (i_cmd == REPRIO_WRITE);
    assign o_map_we     = (i_cmd == MAP_WRITE);
    assign o_fill_start = (i_cmd == START_FILL);     // Ignored by the sequencer when busy

    // ------------------------------
    // Group, page and address regs
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_group    <= '0;
            o_page_idx <= '0;
            o_addr     <= '0;
        end else begin
            case (i_cmd)
                SET_GROUP: o_group    <= i_data[GROUP_LSB +: GROUP_W];    // data[9:5]
                SET_PAGE:  o_page_idx <= i_data[PAGE_LSB +: PAGE_IDX_W];  // data[19:10]
                SET_ADDR:  o_addr     <= i_data;                          // Whole word
                default:   ;
            endcase
        end
    end

    // ------------------------------
    // Read-back selection
    // ------------------------------
    always_comb begin
        rd_cmd = 1'b1;
        rd_sel = '0;
        case (i_cmd)
            MOD_READ:    rd_sel = i_mod_rdata;
            ATTR_READ:   rd_sel = {{(MOD_DATA_W-3){1'b0}}, i_attr_rdata};
            REPRIO_READ: rd_sel = {{(MOD_DATA_W-1){1'b0}}, i_reprio_rdata};
            MAP_READ:    rd_sel = {{(MOD_DATA_W-FRAME_W){1'b0}}, i_map_rdata};
            default:     rd_cmd = 1'b0;              // Not a read
        endcase
    end

    // Valid pulse follows the read command by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= rd_cmd;
        end
    end

    // Sampled before this edge's writes land
    always_ff @(posedge clk) begin
        if (rd_cmd) begin
            o_rdata <= rd_sel;
        end
    end

endmodule

`default_nettype wire

//--- modifier_file.sv
`default_nettype none
`timescale 1ns/1ps

module modifier_file (
    input  wire                               clk,
    input  wire  [mmu_pkg::GROUP_W-1:0]       i_group,        // Current group
    input  wire  [mmu_pkg::MOD_NUM_W-1:0]     i_addr_low,     // Address register low bits
    input  wire  [mmu_pkg::INSTR_MOD_W-1:0]   i_instr_mod,    // Instruction modifier field
    input  wire  [mmu_pkg::MOD_NUM_W-1:0]     i_modnm,        // Microinstruction number
    input  wire  mmu_pkg::mn_src_t            i_mn_src,       // Number source
    input  wire                               i_priv,         // Privileged flag
    input  wire                               i_we,           // Write strobe
    input  wire  [mmu_pkg::MOD_DATA_W-1:0]    i_wdata,
    output logic [mmu_pkg::MOD_DATA_W-1:0]    o_rdata         // Combinational read
);
    import mmu_pkg::*;

    logic [MOD_DATA_W-1:0]        mr_mem [MOD_DEPTH];     // Modifier registers
    logic [MOD_NUM_W-1:0]         mn;                     // Selected modifier number
    logic [GROUP_W+MOD_NUM_W-1:0] mr_idx;                 // Group and number
    logic                         priv_block;             // Upper half without privilege
    logic                         zero_block;             // Entry 0 from U or IRA

    // Number source mux
    always_comb begin
        case (i_mn_src)
            SRC_U:   mn = i_addr_low;
            SRC_IRA: mn = {1'b0, i_instr_mod};     // Top bit forced low
            SRC_MP:  mn = ~i_modnm;                // Stored inverted in microcode
            default: mn = '0;                      // SRC_NONE
        endcase
    end

    assign mr_idx = {i_group, mn};

    // Entries 16..31 are privileged unless the microinstruction names them
    assign priv_block = mn[MOD_NUM_W-1] && (i_mn_src != SRC_MP) && !i_priv;
    assign zero_block = (mn == '0) && (i_mn_src != SRC_MP);

    assign o_rdata = priv_block ? '0 : mr_mem[mr_idx];

    always_ff @(posedge clk) begin
        if (i_we && !priv_block && !zero_block) begin
            mr_mem[mr_idx] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

//--- reprio_fill.sv
`default_nettype none
`timescale 1ns/1ps

module reprio_fill (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               i_start,        // START_FILL command
    input  wire  [mmu_pkg::PAGE_IDX_W-1:0]    i_page_idx,     // First page to fill
    output logic                              o_fill_we,      // Write a one this cycle
    output logic [mmu_pkg::PAGE_IDX_W-1:0]    o_fill_idx,     // Page being filled
    output logic                              o_busy
);
    import mmu_pkg::*;

    localparam logic [PAGE_IDX_W-1:0] LAST_PAGE = PAGE_IDX_W'(PAGE_COUNT - 1);

    fill_state_t           state;
    logic [PAGE_IDX_W-1:0] fcnt;                // Fill counter

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FILL_IDLE;
            fcnt  <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (i_start) begin
                        state <= FILL_RUN;
                        fcnt  <= i_page_idx;   // Start at the current page
                    end
                end
                FILL_RUN: begin
                    if (fcnt == LAST_PAGE) begin
                        state <= FILL_IDLE;    // Drops with the last write
                    end else begin
                        fcnt <= fcnt + 1'b1;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    assign o_busy     = (state == FILL_RUN);
    assign o_fill_we  = (state == FILL_RUN);   // One entry per cycle
    assign o_fill_idx = fcnt;

endmodule

`default_nettype wire

//--- page_attr_store.sv
`default_nettype none
`timescale 1ns/1ps

module page_attr_store (
    input  wire                               clk,
    input  wire  [mmu_pkg::PAGE_IDX_W-1:0]    i_page_idx,     // Physical page register
    input  wire  [mmu_pkg::PAGE_IDX_W-1:0]    i_addr_page,    // Address bits 19..10
    input  wire                               i_attr_we,
    input  wire                               i_reprio_we,
    input  wire                               i_map_we,
    input  wire  [mmu_pkg::MOD_DATA_W-1:0]    i_wdata,        // Command data
    input  wire                               i_fill_we,      // Fill sequencer write
    input  wire  [mmu_pkg::PAGE_IDX_W-1:0]    i_fill_idx,
    output logic [2:0]                        o_attr_rdata,   // {ro, inv, 0}
    output logic                              o_reprio_rdata,
    output logic [mmu_pkg::FRAME_W-1:0]       o_map_rdata
);
    import mmu_pkg::*;

    logic [FRAME_W-1:0]    pg_map    [PAGE_COUNT];   // Page map
    logic                  pg_inv    [PAGE_COUNT];   // Access blocked
    logic                  pg_ro     [PAGE_COUNT];   // Write blocked
    logic                  pg_reprio [PAGE_COUNT];   // Reprioritize request

    // Shared write port of the reprioritize array
    logic                  rp_we;
    logic [PAGE_IDX_W-1:0] rp_idx;
    logic                  rp_bit;

    // ------------------------------
    // Reprioritize write arbiter
    // ------------------------------
    always_comb begin
        if (i_fill_we) begin               // Fill wins, command write is lost
            rp_we  = 1'b1;
            rp_idx = i_fill_idx;
            rp_bit = 1'b1;
        end else begin
            rp_we  = i_reprio_we;
            rp_idx = i_page_idx;
            rp_bit = i_wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rp_we) begin
            pg_reprio[rp_idx] <= rp_bit;
        end
    end

    // ------------------------------
    // Attributes and page map
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_attr_we) begin
            pg_inv[i_page_idx] <= i_wdata[1];
            pg_ro[i_page_idx]  <= i_wdata[2];
        end
        if (i_map_we) begin
            pg_map[i_addr_page] <= i_wdata[FRAME_W-1:0];  // Frame number
        end
    end

    assign o_attr_rdata   = {pg_ro[i_page_idx], pg_inv[i_page_idx], 1'b0};
    assign o_reprio_rdata = pg_reprio[i_page_idx];
    assign o_map_rdata    = pg_map[i_addr_page];

endmodule

`default_nettype wire

//--- mmu_top.sv
`default_nettype none
`timescale 1ns/1ps

module mmu_top (
    input  wire                               clk,          // Clock
    input  wire                               reset,        // Sync reset, active high
    input  wire  mmu_pkg::cmd_op_t            i_cmd,        // Command strobe
    input  wire  [mmu_pkg::MOD_DATA_W-1:0]    i_data,       // Command data
    input  wire  mmu_pkg::mn_src_t            i_mn_src,     // Modifier number source
    input  wire  [mmu_pkg::MOD_NUM_W-1:0]     i_modnm,      // Microinstruction number
    input  wire  [mmu_pkg::INSTR_MOD_W-1:0]   i_instr_mod,  // Instruction modifier field
    input  wire                               i_priv,       // Privileged access
    output logic [mmu_pkg::MOD_DATA_W-1:0]    o_rdata,      // Read data
    output logic                              o_rvalid,     // Read data valid
    output logic                              o_fill_busy   // Bulk fill in progress
);
    import mmu_pkg::*;

    // Register values
    logic [GROUP_W-1:0]    group;
    logic [PAGE_IDX_W-1:0] page_idx;
    logic [MOD_DATA_W-1:0] addr;

    // Command write strobes
    logic                  mod_we;
    logic                  attr_we;
    logic                  reprio_we;
    logic                  map_we;
    logic                  fill_start;

    // Read-back paths
    logic [MOD_DATA_W-1:0] mod_rdata;
    logic [2:0]            attr_rdata;
    logic                  reprio_rdata;
    logic [FRAME_W-1:0]    map_rdata;

    // Fill port into the store
    logic                  fill_we;
    logic [PAGE_IDX_W-1:0] fill_idx;

    // ------------------------------
    // Command decode and registers
    // ------------------------------
    special_regs u_special_regs (
        .clk            (clk),
        .reset          (reset),
        .i_cmd          (i_cmd),
        .i_data         (i_data),
        .i_mod_rdata    (mod_rdata),
        .i_attr_rdata   (attr_rdata),
        .i_reprio_rdata (reprio_rdata),
        .i_map_rdata    (map_rdata),
        .o_group        (group),
        .o_page_idx     (page_idx),
        .o_addr         (addr),
        .o_mod_we       (mod_we),
        .o_attr_we      (attr_we),
        .o_reprio_we    (reprio_we),
        .o_map_we       (map_we),
        .o_fill_start   (fill_start),
        .o_rdata        (o_rdata),
        .o_rvalid       (o_rvalid)
    );

    // ------------------------------
    // Modifier memory
    // ------------------------------
    modifier_file u_modifier_file (
        .clk            (clk),
        .i_group        (group),
        .i_addr_low     (addr[MOD_NUM_W-1:0]),            // U source
        .i_instr_mod    (i_instr_mod),
        .i_modnm        (i_modnm),
        .i_mn_src       (i_mn_src),
        .i_priv         (i_priv),
        .i_we           (mod_we),
        .i_wdata        (i_data),
        .o_rdata        (mod_rdata)
    );

    // ------------------------------
    // Reprioritize fill and store
    // ------------------------------
    reprio_fill u_reprio_fill (
        .clk            (clk),
        .reset          (reset),
        .i_start        (fill_start),
        .i_page_idx     (page_idx),
        .o_fill_we      (fill_we),
        .o_fill_idx     (fill_idx),
        .o_busy         (o_fill_busy)
    );

    page_attr_store u_page_attr_store (
        .clk            (clk),
        .i_page_idx     (page_idx),
        .i_addr_page    (addr[PAGE_LSB +: PAGE_IDX_W]),   // Map index from addr[19:10]
        .i_attr_we      (attr_we),
        .i_reprio_we    (reprio_we),
        .i_map_we       (map_we),
        .i_wdata        (i_data),
        .i_fill_we      (fill_we),
        .i_fill_idx     (fill_idx),
        .o_attr_rdata   (attr_rdata),
        .o_reprio_rdata (reprio_rdata),
        .o_map_rdata    (map_rdata)
    );

endmodule

`default_nettype wire

//--- tb_mmu_model.svh
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

// ------------------------------
// Reference model state
// ------------------------------
logic [MOD_DATA_W-1:0] m_mod    [MOD_DEPTH];      // Unwritten entries stay X
logic                  m_inv    [PAGE_COUNT];
logic                  m_ro     [PAGE_COUNT];
logic                  m_reprio [PAGE_COUNT];
logic [FRAME_W-1:0]    m_map    [PAGE_COUNT];
logic [GROUP_W-1:0]    m_group     = '0;          // Registers clear on reset
logic [PAGE_IDX_W-1:0] m_page      = '0;
logic [MOD_DATA_W-1:0] m_addr      = '0;
int                    m_fill_left = 0;           // Busy cycles still to come

// One call per sampled command, returns the expected read value
function automatic logic [MOD_DATA_W-1:0] mmu_ref(
    input cmd_op_t                  cmd,
    input logic [MOD_DATA_W-1:0]    data,
    input mn_src_t                  src,
    input logic [MOD_NUM_W-1:0]     modnm,
    input logic [INSTR_MOD_W-1:0]   imod,
    input logic                     priv
);
    logic [MOD_DATA_W-1:0]        rd;
    logic [MOD_NUM_W-1:0]         mn;
    logic [GROUP_W+MOD_NUM_W-1:0] mi;
    logic                         locked;
    logic                         busy;
    int                           i;
    rd   = '0;
    busy = (m_fill_left > 0);                     // Fill owns the reprio port
    if (src == SRC_MP) begin
        mn = ~modnm;                              // Microcode number is inverted
    end else if (src == SRC_U) begin
        mn = m_addr[MOD_NUM_W-1:0];
    end else if (src == SRC_IRA) begin
        mn = {1'b0, imod};
    end else begin
        mn = '0;
    end
    mi     = {m_group, mn};
    locked = (mn >= 16) && (src != SRC_MP) && !priv;   // Upper half needs privilege
    case (cmd)
        SET_GROUP:    m_group = data[9:5];
        SET_PAGE:     m_page  = data[19:10];
        SET_ADDR:     m_addr  = data;
        MOD_WRITE: begin
            if (!locked && !(mn == 0 && src != SRC_MP)) begin
                m_mod[mi] = data;                 // Entry 0 only from microcode
            end
        end
        MOD_READ:     rd = locked ? '0 : m_mod[mi];
        ATTR_WRITE: begin
            m_inv[m_page] = data[1];
            m_ro[m_page]  = data[2];
        end
        ATTR_READ:    rd = {29'd0, m_ro[m_page], m_inv[m_page], 1'b0};
        REPRIO_WRITE: begin
            if (!busy) begin
                m_reprio[m_page] = data[0];       // Lost while filling
            end
        end
        REPRIO_READ:  rd = {31'd0, m_reprio[m_page]};
        MAP_WRITE:    m_map[m_addr[19:10]] = data[FRAME_W-1:0];
        MAP_READ:     rd = {12'd0, m_map[m_addr[19:10]]};
        START_FILL: begin
            if (!busy) begin
                for (i = m_page; i < PAGE_COUNT; i++) begin
                    m_reprio[i] = 1'b1;           // Final state of the fill
                end
            end
        end
        default:      ;
    endcase
    if (busy) begin
        m_fill_left = m_fill_left - 1;
    end else if (cmd == START_FILL) begin
        m_fill_left = PAGE_COUNT - m_page;        // Current page to the last one
    end
    return rd;
endfunction

`endif

//--- tb_mmu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int CLK_HALF    = 50;              // 100 ns period
    localparam int RESET_CYC   = 10;
    localparam int FILL_PAGE   = 900;             // First page of the bulk fill
    localparam int RAND_CYC    = 1000;
    localparam int CYCLE_LIMIT = 8000;            // Two full fills, 1200 commands, margin

    logic                   clk;
    logic                   reset;
    cmd_op_t                i_cmd;
    logic [MOD_DATA_W-1:0]  i_data;
    mn_src_t                i_mn_src;
    logic [MOD_NUM_W-1:0]   i_modnm;
    logic [INSTR_MOD_W-1:0] i_instr_mod;
    logic                   i_priv;
    wire  [MOD_DATA_W-1:0]  o_rdata;
    wire                    o_rvalid;
    wire                    o_fill_busy;

    `include "tb_mmu_model.svh"

    logic                  cur_rd;                // Read driven this cycle
    logic [MOD_DATA_W-1:0] cur_exp;
    logic                  exp_vld;               // Read sampled at the last edge
    logic [MOD_DATA_W-1:0] exp_data;
    logic                  busy_seen;             // o_fill_busy at the last drive
    int                    errors       = 0;
    int                    err_mark     = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;
    int                    cycles       = 0;
    integer                seed         = 78896;
    string                 test_name;

    mmu_top UUT (
        .clk         (clk),
        .reset       (reset),
        .i_cmd       (i_cmd),
        .i_data      (i_data),
        .i_mn_src    (i_mn_src),
        .i_modnm     (i_modnm),
        .i_instr_mod (i_instr_mod),
        .i_priv      (i_priv),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid),
        .o_fill_busy (o_fill_busy)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ------------------------------
    // Checks and monitor
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            if (name == "o_rvalid") begin
                if (exp[0]) begin
                    $display("read command at cycle %0d got no o_rvalid", cycles);
                end else begin
                    $display("o_rvalid high at cycle %0d without a read command", cycles);
                end
            end else begin
                $display("mismatch %s: got 0x%h expected 0x%h at cycle %0d",
                         name, got, exp, cycles);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_vld  = 1'b0;
            exp_data = '0;
        end else begin
            check_value("o_rvalid", {31'd0, o_rvalid}, {31'd0, exp_vld});
            if (exp_vld && o_rvalid) begin
                check_value("o_rdata", o_rdata, exp_data);
            end
            exp_vld  = cur_rd;                    // Shows up after this edge
            exp_data = cur_exp;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic issue_cmd(input cmd_op_t cmd, input logic [31:0] data, input mn_src_t src,
                             input logic [4:0] modnm, input logic [3:0] imod,
                             input logic priv);
        @(negedge clk);
        busy_seen   = o_fill_busy;
        i_cmd       = cmd;
        i_data      = data;
        i_mn_src    = src;
        i_modnm     = modnm;
        i_instr_mod = imod;
        i_priv      = priv;
        cur_exp     = mmu_ref(cmd, data, src, modnm, imod, priv);
        cur_rd      = (cmd == MOD_READ) || (cmd == ATTR_READ) ||
                      (cmd == REPRIO_READ) || (cmd == MAP_READ);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic close_test();
        issue_cmd(NOP, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(NOP, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);   // Last read reaches the monitor
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, test_name,
                     errors - err_mark);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int            k;
        int            n;
        logic [31:0]   r;
        logic [31:0]   d;
        cmd_op_t       c;
        reset       = 1'b1;
        i_cmd       = NOP;
        i_data      = '0;
        i_mn_src    = SRC_NONE;
        i_modnm     = '0;
        i_instr_mod = '0;
        i_priv      = 1'b0;
        cur_rd      = 1'b0;
        cur_exp     = '0;
        busy_seen   = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        reset = 1'b0;

        start_test("register and modifier round trip");
        issue_cmd(SET_GROUP, 32'd3 << 5, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'hA5A5_0307, SRC_MP, ~5'd7, 4'd0, 1'b0);
        issue_cmd(SET_GROUP, 32'd9 << 5, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'h5A5A_0907, SRC_MP, ~5'd7, 4'd0, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_MP, ~5'd7, 4'd0, 1'b0);       // Group 9
        issue_cmd(SET_GROUP, 32'd3 << 5, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_MP, ~5'd7, 4'd0, 1'b0);       // Group 3 untouched
        issue_cmd(SET_ADDR, 32'h0001_2407, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_U, 5'd0, 4'd0, 1'b0);         // Same entry via address
        close_test();

        start_test("privilege rules");
        issue_cmd(SET_ADDR, 32'd0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'h1111_0000, SRC_MP, ~5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'hDEAD_0000, SRC_U, 5'd0, 4'd0, 1'b1);   // Entry 0 locked
        issue_cmd(MOD_READ, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(SET_ADDR, 32'd20, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'h2020_2020, SRC_MP, ~5'd20, 4'd0, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_U, 5'd0, 4'd0, 1'b0);         // Zero without priv
        issue_cmd(MOD_READ, '0, SRC_U, 5'd0, 4'd0, 1'b1);
        issue_cmd(MOD_WRITE, 32'hBAD0_0014, SRC_U, 5'd0, 4'd0, 1'b0);  // Dropped
        issue_cmd(MOD_READ, '0, SRC_MP, ~5'd20, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'h600D_0014, SRC_U, 5'd0, 4'd0, 1'b1);
        issue_cmd(MOD_READ, '0, SRC_MP, ~5'd20, 4'd0, 1'b0);
        issue_cmd(MOD_WRITE, 32'h0000_1105, SRC_IRA, 5'd0, 4'd5, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_IRA, 5'd0, 4'd5, 1'b0);
        issue_cmd(MOD_READ, '0, SRC_MP, ~5'd5, 4'd0, 1'b0);
        close_test();

        start_test("page attributes and page map");
        for (k = 0; k < 6; k++) begin
            issue_cmd(SET_PAGE, (k * 37 + 3) << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(ATTR_WRITE, $random(seed), SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(SET_ADDR, ((k * 101 + 5) << 10) | k, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(MAP_WRITE, $random(seed), SRC_NONE, 5'd0, 4'd0, 1'b0);
        end
        for (k = 0; k < 6; k++) begin
            issue_cmd(SET_PAGE, (k * 37 + 3) << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(ATTR_READ, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(SET_ADDR, (k * 101 + 5) << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(MAP_READ, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        end
        close_test();

        start_test("bulk fill");
        for (k = FILL_PAGE - 3; k < FILL_PAGE + 3; k++) begin    // Zeros on both sides of p
            issue_cmd(SET_PAGE, k << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(REPRIO_WRITE, (k == FILL_PAGE - 3), SRC_NONE, 5'd0, 4'd0, 1'b0);
        end
        issue_cmd(SET_PAGE, FILL_PAGE << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
        issue_cmd(START_FILL, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        n = 0;
        issue_cmd(NOP, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        while (busy_seen) begin
            n++;
            if (n == 5) begin
                issue_cmd(REPRIO_WRITE, 32'd0, SRC_NONE, 5'd0, 4'd0, 1'b0);  // Lost
            end else if (n == 10) begin
                issue_cmd(START_FILL, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);  // No restart
            end else begin
                issue_cmd(NOP, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
            end
        end
        check_value("o_fill_busy cycles", n, PAGE_COUNT - FILL_PAGE);
        for (k = FILL_PAGE - 3; k < PAGE_COUNT; k++) begin
            issue_cmd(SET_PAGE, k << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(REPRIO_READ, '0, SRC_NONE, 5'd0, 4'd0, 1'b0);
        end
        close_test();

        start_test("random mix");
        for (k = 0; k < 64; k++) begin            // Every entry of groups 0 and 1
            if (k % 32 == 0) begin
                issue_cmd(SET_GROUP, (k / 32) << 5, SRC_NONE, 5'd0, 4'd0, 1'b0);
            end
            issue_cmd(MOD_WRITE, {~k[15:0], k[15:0]}, SRC_MP, ~k[4:0], 4'd0, 1'b0);
        end
        for (k = 0; k < 8; k++) begin             // Pages 0 to 7
            issue_cmd(SET_PAGE, k << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(ATTR_WRITE, k << 1, SRC_NONE, 5'd0, 4'd0, 1'b0);     // Inv k[0], ro k[1]
            issue_cmd(REPRIO_WRITE, k >> 2, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(SET_ADDR, k << 10, SRC_NONE, 5'd0, 4'd0, 1'b0);
            issue_cmd(MAP_WRITE, 32'h5_A000 | k, SRC_NONE, 5'd0, 4'd0, 1'b0);
        end
        for (k = 0; k < RAND_CYC; k++) begin
            r = $random(seed);
            d = $random(seed);
            c = cmd_op_t'(r[3:0] % 4'd12);        // Everything but START_FILL
            if (c == SET_GROUP) begin
                d[9:6] = '0;                      // Groups 0 and 1
            end
            if (c == SET_PAGE || c == SET_ADDR) begin
                d[19:13] = '0;                    // Pages 0 to 7
            end
            issue_cmd(c, d, mn_src_t'(r[5:4]), r[10:6], r[14:11], r[15]);
        end
        close_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
mmu_pkg.sv
special_regs.sv
modifier_file.sv
reprio_fill.sv
page_attr_store.sv
mmu_top.sv
tb_mmu.sv
